// ==== rtl/mem_access_consts.svh ====
/*
 * Fixed constants of the memory-access front end: segment decode, physical
 * mask, MIPS address-error codes and pipeline stage indices.
 */
`ifndef MEM_ACCESS_CONSTS_SVH
`define MEM_ACCESS_CONSTS_SVH

// Lowest of the three segment select bits (31:29).
`define MA_KSEG1_BIT 29

// kseg0 and kseg1 map onto the low 512 MB.
`define MA_PHYS_MASK 32'h1FFF_FFFF

// Config.K0 value for cacheable, noncoherent kseg0.
`define MA_K0_CACHED 3'd3

// Cause.ExcCode values.
`define MA_EXC_ADEL 5'd4
`define MA_EXC_ADES 5'd5

// Bit positions in the stage vector.
`define MA_STAGE_IF  0
`define MA_STAGE_ID  1
`define MA_STAGE_EX  2
`define MA_STAGE_MEM 3
`define MA_STAGE_WB  4

`endif

// ==== rtl/mem_access_pkg.sv ====
/*
 * Types shared by the translators, the exception controller and the top
 * level. Compile before any other RTL file.
 */
`include "mem_access_consts.svh"

package mem_access_pkg;

    // Virtual address as issued by the core.
    typedef logic [31:0] vaddr_t;

    // Physical address as seen by the bus.
    typedef logic [31:0] paddr_t;

    typedef logic [31:0] data_t;

    // One write strobe per byte lane.
    typedef logic [3:0] byte_en_t;

    // Encoded as the log2 of the byte count, as on the bus.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_t;

    // Cacheability field of the Config register.
    typedef logic [2:0] k0_t;

    typedef logic [4:0] exc_code_t;

    // Bit 0 is IF and bit 4 is WB.
    typedef logic [`MA_STAGE_WB:`MA_STAGE_IF] stage_vec_t;

endpackage

// ==== rtl/mmu_xlate.sv ====
/*
 * Fixed-mapping address translator. One instance serves instruction fetch
 * and one serves data access; each drives its own bus request.
 */
`include "mem_access_consts.svh"

module mmu_xlate (
    input  logic                   en_i,
    input  mem_access_pkg::vaddr_t vaddr_i,
    input  logic                   user_mode_i,
    input  mem_access_pkg::k0_t    k0_i,
    input  logic                   exc_flag_i,
    output logic                   bus_en_o,
    output mem_access_pkg::paddr_t bus_paddr_o,
    output logic                   bus_cached_o,
    output logic                   priv_err_o
);

    import mem_access_pkg::*;

    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    logic [2:0] seg;
    logic       unmapped;
    logic       cached;
    paddr_t     masked_addr;

    assign seg         = vaddr_i[$high(vaddr_i):`MA_KSEG1_BIT];
    assign masked_addr = paddr_t'(vaddr_i) & `MA_PHYS_MASK;

    // kuseg, kseg2 and kseg3 are passed through and always cached.
    always_comb begin
        unmapped = 1'b0;
        cached   = 1'b1;
        case (seg)
            SEG_KSEG0: begin
                unmapped = 1'b1;
                cached   = (k0_i == `MA_K0_CACHED);
            end
            SEG_KSEG1: begin
                unmapped = 1'b1;
                cached   = 1'b0;
            end
            default: begin
                unmapped = 1'b0;
                cached   = 1'b1;
            end
        endcase
    end

    assign bus_paddr_o  = unmapped ? masked_addr : paddr_t'(vaddr_i);
    assign bus_cached_o = cached;

    // User mode may only reach kuseg.
    assign priv_err_o = en_i & user_mode_i & vaddr_i[$high(vaddr_i)];

    // An access that faults anywhere is never put on the bus.
    assign bus_en_o = en_i & ~priv_err_o & ~exc_flag_i;

endmodule

// ==== rtl/addr_exc_ctrl.sv ====
/*
 * Address exception and stall control. Merges privilege and alignment errors
 * of both sides, records the winning exception and builds the stall vector.
 */
`include "mem_access_consts.svh"

module addr_exc_ctrl (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       if_en_i,
    input  mem_access_pkg::vaddr_t     if_vaddr_i,
    input  logic                       if_priv_err_i,
    input  logic                       d_en_i,
    input  logic                       d_write_i,
    input  mem_access_pkg::vaddr_t     d_vaddr_i,
    input  mem_access_pkg::acc_size_t  d_size_i,
    input  logic                       d_priv_err_i,
    input  logic                       ibus_streq_i,
    input  logic                       dbus_streq_i,
    output logic                       exc_flag_o,
    output mem_access_pkg::stage_vec_t stall_o,
    output logic                       exc_valid_o,
    output mem_access_pkg::exc_code_t  exc_code_o,
    output mem_access_pkg::vaddr_t     bad_vaddr_o
);

    import mem_access_pkg::*;

    logic      if_misalign;
    logic      d_misalign;
    logic      if_err;
    logic      d_err;
    exc_code_t exc_code_d;
    vaddr_t    bad_vaddr_d;

    assign if_misalign = if_en_i & (|if_vaddr_i[1:0]); // Fetches are always words.

    always_comb begin
        d_misalign = 1'b0;
        if (d_en_i) begin
            case (d_size_i)
                SIZE_HALF: d_misalign = d_vaddr_i[0];
                SIZE_WORD: d_misalign = |d_vaddr_i[1:0];
                default:   d_misalign = 1'b0; // Byte accesses cannot be misaligned.
            endcase
        end
    end

    assign if_err     = if_priv_err_i | if_misalign;
    assign d_err      = d_priv_err_i | d_misalign;
    assign exc_flag_o = if_err | d_err;

    // The data side belongs to the older instruction, so it wins.
    always_comb begin
        if (d_err) begin
            exc_code_d  = d_write_i ? `MA_EXC_ADES : `MA_EXC_ADEL;
            bad_vaddr_d = d_vaddr_i;
        end else begin
            exc_code_d  = `MA_EXC_ADEL;
            bad_vaddr_d = if_vaddr_i;
        end
    end

    // A data stall holds everything up to MEM; WB always drains.
    always_comb begin
        stall_o = '0;
        if (dbus_streq_i) begin
            stall_o[`MA_STAGE_MEM:`MA_STAGE_IF] = '1;
        end else if (ibus_streq_i) begin
            stall_o[`MA_STAGE_IF] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exc_valid_o <= 1'b0;
            exc_code_o  <= '0;
            bad_vaddr_o <= '0;
        end else begin
            exc_valid_o <= exc_flag_o;
            if (exc_flag_o) begin
                exc_code_o  <= exc_code_d;
                bad_vaddr_o <= bad_vaddr_d; // Held until the next exception.
            end
        end
    end

endmodule

// ==== rtl/mem_access_top.sv ====
/*
 * Memory-access front end of the core. Translates fetch and data addresses
 * in fixed-mapping mode, drives both buses and reports address exceptions.
 */
`include "mem_access_consts.svh"

module mem_access_top (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       user_mode_i,
    input  mem_access_pkg::k0_t        k0_i,

    input  logic                       if_en_i,
    input  mem_access_pkg::vaddr_t     if_vaddr_i,
    output logic                       ibus_en_o,
    output mem_access_pkg::paddr_t     ibus_addr_o,
    output logic                       ibus_cached_o,
    input  logic                       ibus_streq_i,
    output logic                       ibus_stall_o,

    input  logic                       d_en_i,
    input  mem_access_pkg::vaddr_t     d_vaddr_i,
    input  mem_access_pkg::byte_en_t   d_wen_i,
    input  mem_access_pkg::data_t      d_wdata_i,
    input  mem_access_pkg::acc_size_t  d_size_i,
    output logic                       dbus_en_o,
    output mem_access_pkg::paddr_t     dbus_addr_o,
    output logic                       dbus_cached_o,
    output mem_access_pkg::byte_en_t   dbus_wen_o,
    output mem_access_pkg::data_t      dbus_wdata_o,
    output mem_access_pkg::acc_size_t  dbus_size_o,
    input  logic                       dbus_streq_i,
    output logic                       dbus_stall_o,

    output mem_access_pkg::stage_vec_t stall_o,
    output logic                       exc_valid_o,
    output mem_access_pkg::exc_code_t  exc_code_o,
    output mem_access_pkg::vaddr_t     bad_vaddr_o
);

    logic if_priv_err;
    logic d_priv_err;
    logic exc_flag;
    logic d_write;

    assign d_write = |d_wen_i; // Any strobe makes it a store.

    // Strobes, data and size bypass translation.
    assign dbus_wen_o   = d_wen_i;
    assign dbus_wdata_o = d_wdata_i;
    assign dbus_size_o  = d_size_i;

    assign ibus_stall_o = stall_o[`MA_STAGE_IF];
    assign dbus_stall_o = stall_o[`MA_STAGE_MEM];

    mmu_xlate u_immu (
        .en_i         (if_en_i      ),
        .vaddr_i      (if_vaddr_i   ),
        .user_mode_i  (user_mode_i  ),
        .k0_i         (k0_i         ),
        .exc_flag_i   (exc_flag     ),
        .bus_en_o     (ibus_en_o    ),
        .bus_paddr_o  (ibus_addr_o  ),
        .bus_cached_o (ibus_cached_o),
        .priv_err_o   (if_priv_err  )
    );

    mmu_xlate u_dmmu (
        .en_i         (d_en_i       ),
        .vaddr_i      (d_vaddr_i    ),
        .user_mode_i  (user_mode_i  ),
        .k0_i         (k0_i         ),
        .exc_flag_i   (exc_flag     ),
        .bus_en_o     (dbus_en_o    ),
        .bus_paddr_o  (dbus_addr_o  ),
        .bus_cached_o (dbus_cached_o),
        .priv_err_o   (d_priv_err   )
    );

    addr_exc_ctrl u_exc (
        .clk           (clk          ),
        .arst_n_i      (arst_n_i     ),
        .if_en_i       (if_en_i      ),
        .if_vaddr_i    (if_vaddr_i   ),
        .if_priv_err_i (if_priv_err  ),
        .d_en_i        (d_en_i       ),
        .d_write_i     (d_write      ),
        .d_vaddr_i     (d_vaddr_i    ),
        .d_size_i      (d_size_i     ),
        .d_priv_err_i  (d_priv_err   ),
        .ibus_streq_i  (ibus_streq_i ),
        .dbus_streq_i  (dbus_streq_i ),
        .exc_flag_o    (exc_flag     ),
        .stall_o       (stall_o      ),
        .exc_valid_o   (exc_valid_o  ),
        .exc_code_o    (exc_code_o   ),
        .bad_vaddr_o   (bad_vaddr_o  )
    );

endmodule

// ==== verification/tb_mem_access.sv ====
/*
 * Self-checking testbench for the memory-access front end. Reads one test per
 * line from the pattern file, drives the DUT and checks bus and exception outputs.
 */
`include "mem_access_consts.svh"

module tb_mem_access;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_access_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       user_mode;
    k0_t        k0;
    logic       if_en;
    vaddr_t     if_vaddr;
    logic       ibus_streq;
    logic       d_en;
    vaddr_t     d_vaddr;
    byte_en_t   d_wen;
    data_t      d_wdata;
    acc_size_t  d_size;
    logic       dbus_streq;

    logic       ibus_en;
    paddr_t     ibus_addr;
    logic       ibus_cached;
    logic       ibus_stall;
    logic       dbus_en;
    paddr_t     dbus_addr;
    logic       dbus_cached;
    byte_en_t   dbus_wen;
    data_t      dbus_wdata;
    acc_size_t  dbus_size;
    logic       dbus_stall;
    stage_vec_t stall;
    logic       exc_valid;
    exc_code_t  exc_code;
    vaddr_t     bad_vaddr;

    string patterns[$];
    int    err_cnt     = 0;
    int    test_cnt    = 0;
    int    fail_cnt    = 0;
    int    cycle_cnt   = 0;
    int    cycle_limit = 20; // Raised once the pattern file is loaded.

    mem_access_top u_dut (
        .clk           (clk        ),
        .arst_n_i      (arst_n     ),
        .user_mode_i   (user_mode  ),
        .k0_i          (k0         ),
        .if_en_i       (if_en      ),
        .if_vaddr_i    (if_vaddr   ),
        .ibus_en_o     (ibus_en    ),
        .ibus_addr_o   (ibus_addr  ),
        .ibus_cached_o (ibus_cached),
        .ibus_streq_i  (ibus_streq ),
        .ibus_stall_o  (ibus_stall ),
        .d_en_i        (d_en       ),
        .d_vaddr_i     (d_vaddr    ),
        .d_wen_i       (d_wen      ),
        .d_wdata_i     (d_wdata    ),
        .d_size_i      (d_size     ),
        .dbus_en_o     (dbus_en    ),
        .dbus_addr_o   (dbus_addr  ),
        .dbus_cached_o (dbus_cached),
        .dbus_wen_o    (dbus_wen   ),
        .dbus_wdata_o  (dbus_wdata ),
        .dbus_size_o   (dbus_size  ),
        .dbus_streq_i  (dbus_streq ),
        .dbus_stall_o  (dbus_stall ),
        .stall_o       (stall      ),
        .exc_valid_o   (exc_valid  ),
        .exc_code_o    (exc_code   ),
        .bad_vaddr_o   (bad_vaddr  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("error %s %s: expected %b actual %b", name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_paddr(input string name, input string what, input paddr_t exp,
                               input paddr_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h actual %h", name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_stall(input string name, input stage_vec_t exp, input stage_vec_t act);
        if (act !== exp) begin
            $display("error %s stall: expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    // Compares the recorded exception code and bad address.
    task automatic check_exc(input string name, input exc_code_t exp_code,
                             input vaddr_t exp_addr);
        if (exc_code !== exp_code) begin
            $display("error %s exc_code: expected %h actual %h", name, exp_code, exc_code);
            err_cnt++;
        end
        if (bad_vaddr !== exp_addr) begin
            $display("error %s bad_vaddr: expected %h actual %h", name, exp_addr, bad_vaddr);
            err_cnt++;
        end
    endtask

    task automatic check_wdata(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error %s wdata: expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_wen(input string name, input byte_en_t exp, input byte_en_t act);
        if (act !== exp) begin
            $display("error %s wen: expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_size(input string name, input acc_size_t exp, input acc_size_t act);
        if (act !== exp) begin
            $display("error %s size: expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            fail_cnt++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic load_patterns();
        int    fd;
        string line;
        fd = $fopen("verification/mem_access_patterns.txt", "r");
        if (fd == 0) begin
            $display("the pattern file could not be opened");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    patterns.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // Columns are described at the top of the pattern file.
    task automatic apply_pattern(input string line);
        string       name;
        logic [31:0] f [20];
        int          n;
        int          errs_before;
        data_t       wdata;
        stage_vec_t  exp_stall;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
        if (n != 21) begin
            $display("a pattern line could not be parsed: %s", line);
            err_cnt++;
            test_cnt++;
            fail_cnt++;
        end else begin
            errs_before = err_cnt;
            wdata       = $urandom;
            exp_stall   = f[16][4:0];
            @(posedge clk);
            user_mode  <= f[0][0];
            k0         <= f[1][2:0];
            if_en      <= f[2][0];
            if_vaddr   <= f[3];
            ibus_streq <= f[4][0];
            d_en       <= f[5][0];
            d_vaddr    <= f[6];
            d_wen      <= f[7][3:0];
            d_size     <= acc_size_t'(f[8][1:0]);
            d_wdata    <= wdata;
            dbus_streq <= f[9][0];
            #1;
            check_bit(name, "ibus_en", f[10][0], ibus_en);
            check_paddr(name, "ibus_addr", f[11], ibus_addr);
            check_bit(name, "ibus_cached", f[12][0], ibus_cached);
            check_bit(name, "dbus_en", f[13][0], dbus_en);
            check_paddr(name, "dbus_addr", f[14], dbus_addr);
            check_bit(name, "dbus_cached", f[15][0], dbus_cached);
            check_stall(name, exp_stall, stall);
            check_bit(name, "ibus_stall", exp_stall[`MA_STAGE_IF], ibus_stall);
            check_bit(name, "dbus_stall", exp_stall[`MA_STAGE_MEM], dbus_stall);
            if (f[5][0]) begin
                check_wen(name, f[7][3:0], dbus_wen);
                check_wdata(name, wdata, dbus_wdata);
                check_size(name, acc_size_t'(f[8][1:0]), dbus_size);
            end
            @(posedge clk); // The exception is recorded at this edge.
            #1;
            check_bit(name, "exc_valid", f[17][0], exc_valid);
            check_exc(name, f[18][4:0], f[19]);
            report_test(name, errs_before);
        end
    endtask

    initial begin
        int errs_before;
        arst_n     = 1'b0;
        user_mode  = 1'b0;
        k0         = 3'd0;
        if_en      = 1'b0;
        if_vaddr   = '0;
        ibus_streq = 1'b0;
        d_en       = 1'b0;
        d_vaddr    = '0;
        d_wen      = '0;
        d_wdata    = '0;
        d_size     = SIZE_BYTE;
        dbus_streq = 1'b0;
        void'($urandom(32'h5c706f88));
        load_patterns();
        cycle_limit = 4 * patterns.size() + 20;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        #1;
        errs_before = err_cnt;
        check_bit("reset", "exc_valid", 1'b0, exc_valid);
        check_exc("reset", '0, '0);
        report_test("reset", errs_before);
        foreach (patterns[i]) begin
            apply_pattern(patterns[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== verification/mem_access_patterns.txt ====
# Inputs (hex): name user k0 if_en if_vaddr ibus_streq d_en d_vaddr d_wen d_size dbus_streq
# Expected (hex): ibus_en ibus_addr ibus_cached dbus_en dbus_addr dbus_cached stall
#                 exc_valid exc_code bad_vaddr  (d_size 0 byte, 1 half, 2 word)
kseg0_k0c 0 3 1 80001000 0 1 80002004 0 2 0 1 00001000 1 1 00002004 1 00 0 00 00000000
kseg0_k0u 0 2 1 80400000 0 1 9ffffff0 0 2 0 1 00400000 0 1 1ffffff0 0 00 0 00 00000000
kseg1 0 3 1 bfc00000 0 1 a0001234 f 2 0 1 1fc00000 0 1 00001234 0 00 0 00 00000000
kuseg 0 3 1 00400000 0 1 10010008 3 1 0 1 00400000 1 1 10010008 1 00 0 00 00000000
kseg2_kseg3 0 2 1 c0000100 0 1 e0000040 0 0 0 1 c0000100 1 1 e0000040 1 00 0 00 00000000
kseg0_k0_7 0 7 1 80000000 0 1 a0000000 0 2 0 1 00000000 0 1 00000000 0 00 0 00 00000000
kuseg_k0_0 0 0 1 00001000 0 1 7ffffffc 0 2 0 1 00001000 1 1 7ffffffc 1 00 0 00 00000000
user_fetch 1 3 1 80000100 0 0 00000000 0 2 0 0 00000100 1 0 00000000 1 00 1 04 80000100
user_read 1 3 1 00400000 0 1 a0000010 0 2 0 0 00400000 1 0 00000010 0 00 1 04 a0000010
user_write 1 3 0 00000000 0 1 c0000020 1 0 0 0 00000000 1 0 c0000020 1 00 1 05 c0000020
user_kuseg 1 3 1 00400004 0 1 10000000 0 2 0 1 00400004 1 1 10000000 1 00 0 05 c0000020
if_misalign 0 3 1 80000102 0 0 00000000 0 2 0 0 00000102 1 0 00000000 1 00 1 04 80000102
half_misal 0 3 0 00000000 0 1 80001001 0 1 0 0 00000000 1 0 00001001 1 00 1 04 80001001
word_misal_wr 0 3 0 00000000 0 1 80001002 f 2 0 0 00000000 1 0 00001002 1 00 1 05 80001002
word_misal_b0 0 3 0 00000000 0 1 00002001 0 2 0 0 00000000 1 0 00002001 1 00 1 04 00002001
byte_odd 0 3 1 80000000 0 1 80001003 1 0 0 1 00000000 1 1 00001003 1 00 0 04 00002001
half_aligned 0 3 0 00000000 0 1 80001002 0 1 0 0 00000000 1 1 00001002 1 00 0 04 00002001
both_err_wr 0 3 1 80000001 0 1 80000006 c 2 0 0 00000001 1 0 00000006 1 00 1 05 80000006
both_err_user 1 3 1 90000000 0 1 b0000000 0 2 0 0 10000000 1 0 10000000 0 00 1 04 b0000000
if_err_only 0 3 1 00000003 0 1 00000004 f 2 0 0 00000003 1 0 00000004 1 00 1 04 00000003
dbus_stall 0 3 1 80000000 0 1 80000100 0 2 1 1 00000000 1 1 00000100 1 0f 0 04 00000003
both_stall 0 3 1 80000000 1 1 80000100 0 2 1 1 00000000 1 1 00000100 1 0f 0 04 00000003
ibus_stall 0 3 1 80000000 1 1 80000100 0 2 0 1 00000000 1 1 00000100 1 01 0 04 00000003
no_stall 0 3 1 80000000 0 1 80000100 0 2 0 1 00000000 1 1 00000100 1 00 0 04 00000003
stall_on_exc 0 3 0 00000000 0 1 80000102 0 2 1 0 00000000 1 0 00000102 1 0f 1 04 80000102

// ==== verilog.f ====
+incdir+rtl
rtl/mem_access_pkg.sv
rtl/mmu_xlate.sv
rtl/addr_exc_ctrl.sv
rtl/mem_access_top.sv
verification/tb_mem_access.sv

// ==== Bender.yml ====
package:
  name: mem_access

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_access_pkg.sv
      - rtl/mmu_xlate.sv
      - rtl/addr_exc_ctrl.sv
      - rtl/mem_access_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_mem_access.sv
